/* verif/dma_stim.txt */
// test mask sel0-3 src_size snk_size blocks fall0-3 words0-3 pads0-3 (hex)
// fall is the cycle after enable at which enable drops, per channel
1 4 0 0 1 0 6 4 2 0 0 3C 0 0 C 0 0 0 4 0 0
2 1 3 0 0 0 5 3 2 50 0 0 0 0 0 0 A 0 0 0 2
3 2 0 2 0 0 8 6 2 0 18 0 0 0 0 A 0 0 0 2 0
4 3 0 0 0 0 4 4 2 1E 50 0 0 10 0 0 0 8 0 0 0
5 F 3 2 1 0 5 5 1 14 14 14 14 5 5 5 5 5 5 5 5
6 8 0 0 0 1 3 7 3 0 0 0 5A 0 9 0 0 0 5 0 0

/* build.f */
+incdir+hw
hw/dma_pkg.sv
hw/dma_channel.sv
hw/dma_sink_port.sv
hw/dma_sink_router.sv
hw/dma_top.sv
verif/dma_tb.sv

/* Makefile */
TOOL       ?= verilator
SIM_FLAGS  ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= dma_tb
FILELIST   ?= build.f
LOG        ?= sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verif/dma_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module dma_tb;
  import dma_pkg::*;

  localparam int num_ch    = `DMA_CHANNELS;
  localparam int num_tests = 6;
  localparam int fields    = 21;

  logic        clk;
  logic        rst = 1'b1;
  dma_ctrl_t   ctrl    [num_ch] = '{default: '0};
  dma_status_t status  [num_ch];
  src_in_t     src_in  [num_ch] = '{default: '0};
  src_out_t    src_out [num_ch];
  snk_in_t     snk_in  [num_ch] = '{default: '0};
  snk_out_t    snk_out [num_ch];

  logic [31:0]            stim [0:num_tests*fields-1];
  integer                 seed = 77967;
  int                     limit_cycles = 0;
  int                     src_size = 0;
  int                     snk_size = 0;
  logic [1:0]             sel          [num_ch] = '{default: '0};
  int                     blocks_left  [num_ch] = '{default: 0};
  int                     pops         [num_ch] = '{default: 0};
  int                     words        [num_ch] = '{default: 0};
  int                     pads         [num_ch] = '{default: 0};
  int                     blk_words    [num_ch] = '{default: 0};
  logic                   prev_src_act [num_ch] = '{default: 1'b0};
  logic [1:0]             prev_snk_act [num_ch] = '{default: 2'b00};
  logic [`DMA_DATA_W-1:0] exp_q        [num_ch][$];

  dma_top dut (
    .clk      (clk),
    .rst      (rst),
    .i_ctrl   (ctrl),
    .o_status (status),
    .i_src    (src_in),
    .o_src    (src_out),
    .i_snk    (snk_in),
    .o_snk    (snk_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_status(input int ch, input dma_status_t got, input dma_status_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERROR at %0t: channel %0d status %h, expected %h",
                                  $time, ch, got, exp));
    end
  endtask

  task automatic check_snk_word(input int s, input snk_out_t got, input snk_out_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERROR at %0t: sink %0d output %h, expected %h",
                                  $time, s, got, exp));
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      stop_with_failure($sformatf("ERROR at %0t: %s is %0d, expected %0d",
                                  $time, what, got, exp));
    end
  endtask

  // Source and sink FIFO models, sampled where DUT outputs are stable
  always @(negedge clk) begin
    logic [`DMA_DATA_W-1:0] word;
    for (int c = 0; c < num_ch; c++) begin
      if (rst) begin
        src_in[c].data <= $random(seed);
      end else if (src_out[c].strobe) begin
        pops[c]++;
        // Pops after enable falls are flushed and never reach a sink
        if (ctrl[c].enable) begin
          exp_q[sel[c]].push_back(src_in[c].data);
        end
        src_in[c].data <= $random(seed);
      end
      if (prev_src_act[c] && !src_out[c].activate) begin
        blocks_left[c]--;
      end
      prev_src_act[c] = src_out[c].activate;
      src_in[c].ready <= blocks_left[c] > 0;
      src_in[c].size  <= src_size;
    end
    for (int s = 0; s < num_ch; s++) begin
      if (!rst && prev_snk_act[s] == 2'b00 && snk_out[s].activate != 2'b00) begin
        check_count($sformatf("sink %0d first activate", s), snk_out[s].activate, 1);
      end
      // A sink block is complete when its activate drops
      if (!rst && prev_snk_act[s] != 2'b00 && snk_out[s].activate == 2'b00) begin
        check_count($sformatf("sink %0d block words", s), blk_words[s], snk_size);
        blk_words[s] = 0;
      end
      prev_snk_act[s] = snk_out[s].activate;
      if (!rst && snk_out[s].strobe) begin
        blk_words[s]++;
        if (exp_q[s].size() > 0) begin
          word = exp_q[s].pop_front();
          words[s]++;
        end else begin
          word = '0;
          pads[s]++;
        end
        // Both halves are ready whenever the sink is idle, so half 0 takes every block
        check_snk_word(s, snk_out[s], '{activate: 2'b01, strobe: 1'b1, data: word});
      end
      // A half is ready again once its block completes
      snk_in[s].ready <= ~snk_out[s].activate;
      snk_in[s].size  <= snk_size;
    end
  end

  task automatic run_test(input int t);
    int         base;
    logic [3:0] mask;
    int         cyc;
    bit         done;
    bit         fin_seen [num_ch];
    base     = t * fields;
    mask     = stim[base+1][3:0];
    src_size = stim[base+6];
    snk_size = stim[base+7];
    for (int c = 0; c < num_ch; c++) begin
      sel[c]         = stim[base+2+c][1:0];
      blocks_left[c] = mask[c] ? int'(stim[base+8]) : 0;
      pops[c]        = 0;
      words[c]       = 0;
      pads[c]        = 0;
      fin_seen[c]    = 1'b0;
      ctrl[c] <= '{reserved: '0, sink_sel: sel[c], enable: 1'b0};
    end
    repeat (2) @(negedge clk);
    for (int c = 0; c < num_ch; c++) begin
      if (mask[c]) ctrl[c].enable <= 1'b1;
    end
    cyc  = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      cyc++;
      done = 1'b1;
      for (int c = 0; c < num_ch; c++) begin
        if (mask[c]) begin
          if (cyc == stim[base+9+c]) begin
            ctrl[c].enable <= 1'b0;
          end
          // Busy from the cycle after enable, finished stays set once seen
          if (fin_seen[c] || status[c].finished) begin
            fin_seen[c] = 1'b1;
            check_status(c, status[c], '{reserved: '0, finished: 1'b1, busy: 1'b0});
          end else begin
            check_status(c, status[c], '{reserved: '0, finished: 1'b0, busy: 1'b1});
            done = 1'b0;
          end
        end
      end
    end
    for (int c = 0; c < num_ch; c++) begin
      if (mask[c]) begin
        check_count($sformatf("test %0d channel %0d pops", t + 1, c), pops[c],
                    src_size * int'(stim[base+8]));
      end
    end
    for (int s = 0; s < num_ch; s++) begin
      check_count($sformatf("test %0d sink %0d words", t + 1, s), words[s], stim[base+13+s]);
      check_count($sformatf("test %0d sink %0d pads", t + 1, s), pads[s], stim[base+17+s]);
      check_count($sformatf("test %0d sink %0d lost words", t + 1, s), exp_q[s].size(), 0);
    end
  endtask

  initial begin
    $readmemh("verif/dma_stim.txt", stim);
    for (int t = 0; t < num_tests; t++) begin
      limit_cycles += 200 * int'(stim[t*fields+6]) * int'(stim[t*fields+8]);
    end
    repeat (4) @(negedge clk);
    rst <= 1'b0;
    @(negedge clk);
    for (int c = 0; c < num_ch; c++) begin
      check_status(c, status[c], '0);
      check_count($sformatf("channel %0d source outputs", c), src_out[c], 0);
      check_snk_word(c, snk_out[c], '0);
    end
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    stop_with_failure($sformatf("Timeout: the tests did not complete within %0d cycles",
                                limit_cycles));
  end

endmodule

`default_nettype wire

/* hw/dma_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module dma_top (
  input  wire                         clk,
  input  wire                         rst,
  input  wire dma_pkg::dma_ctrl_t     i_ctrl   [`DMA_CHANNELS],
  output dma_pkg::dma_status_t        o_status [`DMA_CHANNELS],
  input  wire dma_pkg::src_in_t       i_src    [`DMA_CHANNELS],
  output dma_pkg::src_out_t           o_src    [`DMA_CHANNELS],
  input  wire dma_pkg::snk_in_t       i_snk    [`DMA_CHANNELS],
  output dma_pkg::snk_out_t           o_snk    [`DMA_CHANNELS]
);
  import dma_pkg::*;

  // Channel side of the crossbar
  snk_req_t                   ch_req      [`DMA_CHANNELS];
  snk_rsp_t                   ch_rsp      [`DMA_CHANNELS];
  logic [`DMA_SINK_SEL_W-1:0] ch_sink_sel [`DMA_CHANNELS];

  // Sink side of the crossbar
  snk_req_t                   port_req    [`DMA_CHANNELS];
  snk_rsp_t                   port_rsp    [`DMA_CHANNELS];

  genvar g;

  for (g = 0; g < `DMA_CHANNELS; g++) begin : g_channel
    dma_channel u_channel (
      .clk        (clk),
      .rst        (rst),
      .i_ctrl     (i_ctrl[g]),
      .i_src      (i_src[g]),
      .o_src      (o_src[g]),
      .i_rsp      (ch_rsp[g]),
      .o_req      (ch_req[g]),
      .o_sink_sel (ch_sink_sel[g]),
      .o_status   (o_status[g])
    );
  end

  dma_sink_router u_router (
    .i_req      (ch_req),
    .i_sink_sel (ch_sink_sel),
    .o_req      (port_req),
    .i_rsp      (port_rsp),
    .o_rsp      (ch_rsp)
  );

  for (g = 0; g < `DMA_CHANNELS; g++) begin : g_sink
    dma_sink_port u_sink (
      .clk   (clk),
      .rst   (rst),
      .i_req (port_req[g]),
      .i_snk (i_snk[g]),
      .o_snk (o_snk[g]),
      .o_rsp (port_rsp[g])
    );
  end

endmodule

`default_nettype wire

/* hw/dma_sink_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module dma_sink_router (
  input  wire dma_pkg::snk_req_t         i_req      [`DMA_CHANNELS],
  input  wire [`DMA_SINK_SEL_W-1:0]      i_sink_sel [`DMA_CHANNELS],
  output dma_pkg::snk_req_t              o_req      [`DMA_CHANNELS],
  input  wire dma_pkg::snk_rsp_t         i_rsp      [`DMA_CHANNELS],
  output dma_pkg::snk_rsp_t              o_rsp      [`DMA_CHANNELS]
);

  localparam int sel_w = `DMA_SINK_SEL_W;

  logic [`DMA_CHANNELS-1:0] owned;
  logic [sel_w-1:0]         owner [`DMA_CHANNELS];

  always_comb begin
    for (int s = 0; s < `DMA_CHANNELS; s++) begin
      owned[s] = 1'b0;
      owner[s] = '0;
    end
    // Walk downward so the lowest claiming channel wins
    for (int c = `DMA_CHANNELS - 1; c >= 0; c--) begin
      if (i_req[c].claim) begin
        owned[i_sink_sel[c]] = 1'b1;
        owner[i_sink_sel[c]] = sel_w'(c);
      end
    end
  end

  always_comb begin
    for (int s = 0; s < `DMA_CHANNELS; s++) begin
      o_req[s] = owned[s] ? i_req[owner[s]] : '0;
    end
    // Non-owners see an idle sink and wait
    for (int c = 0; c < `DMA_CHANNELS; c++) begin
      if (owned[i_sink_sel[c]] && (owner[i_sink_sel[c]] == sel_w'(c))) begin
        o_rsp[c] = i_rsp[i_sink_sel[c]];
      end else begin
        o_rsp[c] = '0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/dma_sink_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module dma_sink_port (
  input  wire                     clk,
  input  wire                     rst,
  input  wire dma_pkg::snk_req_t  i_req,
  input  wire dma_pkg::snk_in_t   i_snk,
  output dma_pkg::snk_out_t       o_snk,
  output dma_pkg::snk_rsp_t       o_rsp
);

  logic [1:0]             activate;
  logic [`DMA_SIZE_W-1:0] count;
  logic                   strobe;
  logic [`DMA_DATA_W-1:0] data;
  logic                   active;
  logic                   room;

  assign active = |activate;
  assign room   = count < i_snk.size;

  always_ff @(posedge clk) begin
    if (rst) begin
      activate <= 2'b00;
      count    <= '0;
      strobe   <= 1'b0;
      data     <= '0;
    end else begin
      strobe <= 1'b0;

      if (!active) begin
        // No new block once the owner is padding
        if (i_req.claim && !i_req.pad && (|i_snk.ready)) begin
          count <= '0;
          // Half 0 first
          if (i_snk.ready[0]) begin
            activate <= 2'b01;
          end else begin
            activate <= 2'b10;
          end
        end
      end else if (!room) begin
        activate <= 2'b00;
      end else if (i_req.pad) begin
        strobe <= 1'b1;
        data   <= '0;
        count  <= count + 1'b1;
      end else if (i_req.write) begin
        strobe <= 1'b1;
        data   <= i_req.data;
        count  <= count + 1'b1;
      end
    end
  end

  assign o_snk = '{activate: activate, strobe: strobe, data: data};

  // Accept only while the active half still has space
  assign o_rsp = '{accept: active && room, active: active};

endmodule

`default_nettype wire

/* hw/dma_channel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module dma_channel (
  input  wire                        clk,
  input  wire                        rst,
  input  wire  dma_pkg::dma_ctrl_t   i_ctrl,
  input  wire  dma_pkg::src_in_t     i_src,
  output dma_pkg::src_out_t          o_src,
  input  wire  dma_pkg::snk_rsp_t    i_rsp,
  output dma_pkg::snk_req_t          o_req,
  output logic [`DMA_SINK_SEL_W-1:0] o_sink_sel,
  output dma_pkg::dma_status_t       o_status
);
  import dma_pkg::*;

  dma_state_e             state;
  logic [`DMA_SIZE_W-1:0] src_count;
  logic                   src_active;
  logic                   src_strobe;
  logic                   finished;
  logic                   src_done;
  logic                   move;

  assign src_done = src_count >= i_src.size;

  // The head word only advances once the previous pop has landed,
  // so a move waits out a strobe still in flight
  assign move = (state == ACTIVE) && i_ctrl.enable && src_active && !src_done &&
                !src_strobe && i_rsp.accept;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      src_count  <= '0;
      src_active <= 1'b0;
      src_strobe <= 1'b0;
      finished   <= 1'b0;
      o_sink_sel <= '0;
    end else begin
      src_strobe <= 1'b0;

      // Block fully consumed, release the source
      if (src_active && src_done) begin
        src_active <= 1'b0;
      end

      case (state)
        IDLE: begin
          if (i_ctrl.enable) begin
            state      <= ACTIVE;
            o_sink_sel <= i_ctrl.sink_sel;
            finished   <= 1'b0;
          end
        end

        ACTIVE: begin
          if (!i_ctrl.enable) begin
            state <= FLUSH;
          end else if (!src_active && i_src.ready) begin
            src_active <= 1'b1;
            src_count  <= '0;
          end else if (move) begin
            src_strobe <= 1'b1;
            src_count  <= src_count + 1'b1;
          end
        end

        FLUSH: begin
          // Drain the source block, words are dropped
          if (src_active && !src_done) begin
            src_strobe <= 1'b1;
            src_count  <= src_count + 1'b1;
          end else if (!src_active && !i_rsp.active) begin
            state    <= IDLE;
            finished <= 1'b1;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign o_src = '{activate: src_active, strobe: src_strobe};

  // Sink port pads with zeros while pad is held
  assign o_req = '{
    claim: state != IDLE,
    write: move,
    pad:   state == FLUSH,
    data:  i_src.data
  };

  assign o_status = '{reserved: '0, finished: finished, busy: state != IDLE};

endmodule

`default_nettype wire

/* hw/dma_pkg.sv */
`default_nettype none

`include "dma_config.svh"

package dma_pkg;

  // Per-channel control word
  typedef struct packed {
    logic [30-`DMA_SINK_SEL_W:0] reserved;
    logic [`DMA_SINK_SEL_W-1:0]  sink_sel;
    logic                        enable;
  } dma_ctrl_t;

  // Per-channel status word
  typedef struct packed {
    logic [29:0] reserved;
    logic        finished;
    logic        busy;
  } dma_status_t;

  typedef struct packed {
    logic                   ready;
    logic [`DMA_SIZE_W-1:0] size;
    logic [`DMA_DATA_W-1:0] data;
  } src_in_t;

  typedef struct packed {
    logic activate;
    logic strobe;
  } src_out_t;

  // Ready bit per ping-pong half
  typedef struct packed {
    logic [1:0]             ready;
    logic [`DMA_SIZE_W-1:0] size;
  } snk_in_t;

  typedef struct packed {
    logic [1:0]             activate;
    logic                   strobe;
    logic [`DMA_DATA_W-1:0] data;
  } snk_out_t;

  // Channel to sink port, through the router
  typedef struct packed {
    logic                   claim;
    logic                   write;
    logic                   pad;
    logic [`DMA_DATA_W-1:0] data;
  } snk_req_t;

  typedef struct packed {
    logic accept;
    logic active;
  } snk_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    ACTIVE,
    FLUSH
  } dma_state_e;

endpackage

`default_nettype wire

/* hw/dma_config.svh */
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Channel count, also the number of sink ports
`define DMA_CHANNELS 4

// Width of one FIFO word
`define DMA_DATA_W 32

// Block length width, matches the FIFO size ports
`define DMA_SIZE_W 24

// Sink select field in the control word
`define DMA_SINK_SEL_W 2

`endif
